//--- Bender.yml
package:
  name: aes_stream

sources:
  # rtl
  - files:
      - common/aes_pkg.sv
      - common/aes_core_if.sv
      - aes_cipher/aes_round.sv
      - aes_cipher/aes_cipher_core.sv
      - design/aes_block_loader.sv
      - design/aes_block_writer.sv
      - design/aes_stream_top.sv
  # verif
  - target: verif
    files:
      - verif/tb_clock_gen.sv
      - verif/aes_stream_sva.sv
      - verif/aes_stream_tb.sv

//--- aes_cipher/aes_cipher_core.sv
`timescale 1ns/1ps
`default_nettype none

module aes_cipher_core (
	input  logic                      clk,
	input  logic                      reset,
	aes_core_if.core                  core,
	input  logic                      writer_free,
	output logic                      result_valid,
	output logic [aes_pkg::BLK_W-1:0] result_block
);

	aes_pkg::aes_state_u state_q;
	aes_pkg::aes_state_u rkey_q; // key of the round just applied
	aes_pkg::aes_state_u next_key;
	aes_pkg::aes_state_u round_out;
	logic [7:0]          rcon_q;
	logic [3:0]          round_q;
	logic                running;
	logic                holding; // final state waits for the writer
	logic                last_round;

	assign last_round = (round_q == 4'(aes_pkg::NUM_ROUNDS));

	// key schedule, one round key per cycle
	always_comb begin
		logic [31:0] w3;
		logic [31:0] temp;
		w3 = rkey_q.cols[3];
		temp = {aes_pkg::sbox(w3[23:16]), aes_pkg::sbox(w3[15:8]),
			aes_pkg::sbox(w3[7:0]), aes_pkg::sbox(w3[31:24])};
		temp = temp ^ {rcon_q, 24'h000000};
		next_key.cols[0] = rkey_q.cols[0] ^ temp;
		next_key.cols[1] = rkey_q.cols[1] ^ next_key.cols[0];
		next_key.cols[2] = rkey_q.cols[2] ^ next_key.cols[1];
		next_key.cols[3] = rkey_q.cols[3] ^ next_key.cols[2];
	end

	aes_round u_round (
		.state_in    (state_q),
		.round_key   (next_key),
		.final_round (last_round),
		.state_out   (round_out)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			holding <= 1'b0;
			round_q <= '0;
		end else begin
			if (core.start) begin
				running <= 1'b1;
				round_q <= 4'd1;
			end else if (running) begin
				round_q <= round_q + 4'd1;
				if (last_round) begin
					running <= 1'b0;
					holding <= 1'b1;
				end
			end else if (holding && writer_free) begin
				holding <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (core.start) begin
			state_q <= core.block ^ core.key; // initial AddRoundKey
			rkey_q <= core.key;
			rcon_q <= aes_pkg::RCON_INIT;
		end else if (running) begin
			state_q <= round_out;
			rkey_q <= next_key;
			rcon_q <= aes_pkg::xtime(rcon_q);
		end
	end

	assign core.busy = running || holding;
	assign result_valid = holding && writer_free;
	assign result_block = state_q;

endmodule

`default_nettype wire

//--- aes_cipher/aes_round.sv
`timescale 1ns/1ps
`default_nettype none

module aes_round (
	input  aes_pkg::aes_state_u       state_in,
	input  logic [aes_pkg::BLK_W-1:0] round_key,
	input  logic                      final_round,
	output aes_pkg::aes_state_u       state_out
);

	aes_pkg::aes_state_u shifted;
	aes_pkg::aes_state_u mixed;

	// SubBytes and ShiftRows, row r rotates left by r columns
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted.bytes[4*c + r] = aes_pkg::sbox(state_in.bytes[4*((c + r) % 4) + r]);
			end
		end
	end

	always_comb begin
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		for (int c = 0; c < 4; c++) begin
			{a0, a1, a2, a3} = shifted.cols[c];
			mixed.cols[c] = {
				aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3,
				a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3,
				a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3,
				aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3)
			};
		end
	end

	// last round has no MixColumns
	always_comb begin
		if (final_round)
			state_out.cols = shifted.cols ^ round_key;
		else
			state_out.cols = mixed.cols ^ round_key;
	end

endmodule

`default_nettype wire

//--- common/aes_core_if.sv
`timescale 1ns/1ps
`default_nettype none

interface aes_core_if;

	logic                      start; // one-cycle pulse, only while busy is low
	logic [aes_pkg::BLK_W-1:0] block; // cbc chaining already applied
	logic [aes_pkg::BLK_W-1:0] key;
	logic                      busy;

	modport loader (
		output start, block, key,
		input  busy
	);

	modport core (
		input  start, block, key,
		output busy
	);

endinterface

`default_nettype wire

//--- common/aes_pkg.sv
`default_nettype none

package aes_pkg;

	localparam int BLK_W      = 128;
	localparam int NUM_ROUNDS = 10;

	localparam logic [7:0] RCON_INIT = 8'h01;

	// loader states
	localparam logic [1:0] LD_GET_KEY     = 2'd0;
	localparam logic [1:0] LD_GET_IV      = 2'd1;
	localparam logic [1:0] LD_WAIT_BLOCK  = 2'd2;
	localparam logic [1:0] LD_WAIT_RESULT = 2'd3;

	// forward s-box, entry 0 in the top byte
	localparam logic [0:255][7:0] SBOX_TABLE = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// bytes[0] is in0 of FIPS-197; cols[c] holds bytes 4c..4c+3
	typedef union packed {
		logic [0:15][7:0] bytes;
		logic [0:3][31:0] cols;
	} aes_state_u;

	function automatic logic [7:0] sbox(input logic [7:0] b);
		return SBOX_TABLE[b];
	endfunction

	// multiply by x modulo x^8+x^4+x^3+x+1
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

`default_nettype wire

//--- design/aes_block_loader.sv
`timescale 1ns/1ps
`default_nettype none

module aes_block_loader (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [aes_pkg::BLK_W-1:0] in_tdata,
	input  logic                      in_tvalid,
	output logic                      in_tready,
	input  logic                      cbc,
	input  logic                      source_done,
	output logic                      processing_done,
	input  logic                      result_valid,
	input  logic [aes_pkg::BLK_W-1:0] result_block,
	aes_core_if.loader                core
);

	logic [1:0]                state;
	logic                      cbc_q; // mode of the running session
	logic [aes_pkg::BLK_W-1:0] iv;
	logic                      in_beat;

	assign in_beat = in_tvalid && in_tready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= aes_pkg::LD_GET_KEY;
			in_tready <= 1'b0;
			core.start <= 1'b0;
			processing_done <= 1'b0;
			cbc_q <= 1'b0;
		end else begin
			core.start <= 1'b0;
			processing_done <= 1'b0;

			case (state)
				aes_pkg::LD_GET_KEY: begin
					in_tready <= 1'b1;
					if (in_beat) begin
						cbc_q <= cbc;
						state <= cbc ? aes_pkg::LD_GET_IV : aes_pkg::LD_WAIT_BLOCK;
					end
				end
				aes_pkg::LD_GET_IV: begin
					in_tready <= 1'b1;
					if (in_beat)
						state <= aes_pkg::LD_WAIT_BLOCK;
				end
				aes_pkg::LD_WAIT_BLOCK: begin
					in_tready <= !core.busy;
					if (in_beat) begin
						in_tready <= 1'b0;
						core.start <= 1'b1;
						state <= aes_pkg::LD_WAIT_RESULT;
					end else if (source_done && !in_tvalid && !core.busy) begin
						processing_done <= 1'b1; // session over, next beat is a key
						state <= aes_pkg::LD_GET_KEY;
					end
				end
				aes_pkg::LD_WAIT_RESULT: begin
					// core is idle again in the cycle after the handover
					in_tready <= result_valid;
					if (result_valid)
						state <= aes_pkg::LD_WAIT_BLOCK;
				end
				default: begin
					in_tready <= 1'b0;
					state <= aes_pkg::LD_GET_KEY;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_beat) begin
			case (state)
				aes_pkg::LD_GET_KEY:
					core.key <= in_tdata;
				aes_pkg::LD_GET_IV:
					iv <= in_tdata;
				aes_pkg::LD_WAIT_BLOCK:
					core.block <= cbc_q ? (in_tdata ^ iv) : in_tdata;
				default: ;
			endcase
		end

		// next block chains on this ciphertext
		if (state == aes_pkg::LD_WAIT_RESULT && result_valid && cbc_q)
			iv <= result_block;
	end

endmodule

`default_nettype wire

//--- design/aes_block_writer.sv
`timescale 1ns/1ps
`default_nettype none

module aes_block_writer (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      result_valid,
	input  logic [aes_pkg::BLK_W-1:0] result_block,
	output logic                      writer_free,
	output logic [aes_pkg::BLK_W-1:0] out_tdata,
	output logic                      out_tvalid,
	input  logic                      out_tready
);

	// empty, or the held block leaves this cycle
	assign writer_free = !out_tvalid || out_tready;

	always_ff @(posedge clk) begin
		if (reset)
			out_tvalid <= 1'b0;
		else if (writer_free)
			out_tvalid <= result_valid;
	end

	always_ff @(posedge clk) begin
		if (result_valid)
			out_tdata <= result_block; // only offered while writer_free
	end

endmodule

`default_nettype wire

//--- design/aes_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_stream_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [aes_pkg::BLK_W-1:0] in_tdata,
	input  logic                      in_tvalid,
	output logic                      in_tready,
	input  logic                      cbc,
	input  logic                      source_done,
	output logic [aes_pkg::BLK_W-1:0] out_tdata,
	output logic                      out_tvalid,
	input  logic                      out_tready,
	output logic                      processing_done
);

	logic                      result_valid;
	logic [aes_pkg::BLK_W-1:0] result_block;
	logic                      writer_free;

	aes_core_if u_core_if ();

	aes_block_loader u_loader (
		.clk             (clk),
		.reset           (reset),
		.in_tdata        (in_tdata),
		.in_tvalid       (in_tvalid),
		.in_tready       (in_tready),
		.cbc             (cbc),
		.source_done     (source_done),
		.processing_done (processing_done),
		.result_valid    (result_valid),
		.result_block    (result_block),
		.core            (u_core_if.loader)
	);

	aes_cipher_core u_cipher (
		.clk          (clk),
		.reset        (reset),
		.core         (u_core_if.core),
		.writer_free  (writer_free),
		.result_valid (result_valid),
		.result_block (result_block)
	);

	aes_block_writer u_writer (
		.clk          (clk),
		.reset        (reset),
		.result_valid (result_valid),
		.result_block (result_block),
		.writer_free  (writer_free),
		.out_tdata    (out_tdata),
		.out_tvalid   (out_tvalid),
		.out_tready   (out_tready)
	);

endmodule

`default_nettype wire

//--- project.f
common/aes_pkg.sv
common/aes_core_if.sv
aes_cipher/aes_round.sv
aes_cipher/aes_cipher_core.sv
design/aes_block_loader.sv
design/aes_block_writer.sv
design/aes_stream_top.sv
verif/tb_clock_gen.sv
verif/aes_stream_sva.sv
verif/aes_stream_tb.sv

//--- verif/aes_stimulus.txt
# S cbc stall key iv : session, stall 1 gives random out_tready
# B plaintext expected_ciphertext : one block, E ends the session
S 0 0 000102030405060708090a0b0c0d0e0f 00000000000000000000000000000000
B 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
E
S 0 1 2b7e151628aed2a6abf7158809cf4f3c 00000000000000000000000000000000
B 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
B ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
B 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
B f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
E
S 1 1 2b7e151628aed2a6abf7158809cf4f3c 000102030405060708090a0b0c0d0e0f
B 6bc1bee22e409f96e93d7e117393172a 7649abac8119b246cee98e9b12e9197d
B ae2d8a571e03ac9c9eb76fac45af8e51 5086cb9b507219ee95db113a917678b2
B 30c81c46a35ce411e5fbc1191a0a52ef 73bed6b8e3c1743b7116e69e22229516
B f69f2445df4f9b17ad2b417be66c3710 3ff1caa1681fac09120eca307586e1a7
E
S 0 1 000102030405060708090a0b0c0d0e0f 00000000000000000000000000000000
B 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
E

//--- verif/aes_stream_sva.sv
`timescale 1ns/1ps
`default_nettype none

module aes_stream_sva (
	input logic                      clk,
	input logic                      reset,
	input logic                      in_tready,
	input logic                      out_tvalid,
	input logic                      out_tready,
	input logic [aes_pkg::BLK_W-1:0] out_tdata,
	input logic                      processing_done
);

	int assert_fails = 0; // read by the testbench at the end of the run

	property out_hold;
		@(posedge clk) disable iff (reset)
		out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata);
	endproperty

	property done_single;
		@(posedge clk) disable iff (reset)
		processing_done |=> !processing_done;
	endproperty

	property reset_idle;
		@(posedge clk) reset |=> !in_tready && !out_tvalid;
	endproperty

	a_out_hold: assert property (out_hold) else begin
		$error("out_tvalid dropped or out_tdata changed while the beat was stalled");
		assert_fails++;
	end

	a_done_single: assert property (done_single) else begin
		$error("processing_done stayed high for two cycles");
		assert_fails++;
	end

	a_reset_idle: assert property (reset_idle) else begin
		$error("in_tready or out_tvalid high in the cycle after reset");
		assert_fails++;
	end

endmodule

bind aes_stream_top aes_stream_sva u_sva (
	.clk             (clk),
	.reset           (reset),
	.in_tready       (in_tready),
	.out_tvalid      (out_tvalid),
	.out_tready      (out_tready),
	.out_tdata       (out_tdata),
	.processing_done (processing_done)
);

`default_nettype wire

//--- verif/aes_stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes_stream_tb;

	localparam int MAX_STALL    = 3;  // longest run of out_tready low
	localparam int BLOCK_CYCLES = 13; // plaintext beat to output transfer without stalls

	logic                      clk;
	logic                      reset;
	logic [aes_pkg::BLK_W-1:0] in_tdata;
	logic                      in_tvalid;
	logic                      in_tready;
	logic                      cbc;
	logic                      source_done;
	logic [aes_pkg::BLK_W-1:0] out_tdata;
	logic                      out_tvalid;
	logic                      out_tready;
	logic                      processing_done;

	logic                      sess_cbc [$];
	logic                      sess_stall [$];
	logic [aes_pkg::BLK_W-1:0] sess_key [$];
	logic [aes_pkg::BLK_W-1:0] sess_iv [$];
	int                        sess_nblk [$];
	logic [aes_pkg::BLK_W-1:0] blk_pt [$];
	logic [aes_pkg::BLK_W-1:0] blk_ct [$];

	logic [aes_pkg::BLK_W-1:0] exp_q [$]; // scoreboard
	int                        beat_q [$]; // beat cycles of unstalled blocks
	int                        cycle = 0;
	int                        limit = 1000;
	int                        last_beat_cycle;
	int                        done_pulses = 0;
	int                        error_count = 0;
	int                        tests_run = 0;
	int                        tests_failed = 0;
	int                        stall_run = 0;
	logic                      stall_en;
	logic                      check_latency;
	logic [31:0]               rng = 32'h78b1555b;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	aes_stream_top u_aes_stream_top (
		.clk             (clk),
		.reset           (reset),
		.in_tdata        (in_tdata),
		.in_tvalid       (in_tvalid),
		.in_tready       (in_tready),
		.cbc             (cbc),
		.source_done     (source_done),
		.out_tdata       (out_tdata),
		.out_tvalid      (out_tvalid),
		.out_tready      (out_tready),
		.processing_done (processing_done)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Done: errors found");
			$finish;
		end
	end

	// random back-pressure with capped runs of low ready
	always @(negedge clk) begin
		rng = lcg_step(rng);
		if (stall_en && rng[31] && stall_run < MAX_STALL) begin
			out_tready = 1'b0;
			stall_run++;
		end else begin
			out_tready = 1'b1;
			stall_run = 0;
		end
	end

	always @(posedge clk) begin
		logic [aes_pkg::BLK_W-1:0] expected;
		int latency;
		if (!reset && processing_done)
			done_pulses++;
		if (!reset && out_tvalid && out_tready) begin
			assert (exp_q.size() != 0) else begin
				$display("Error at %0t: output block %h arrived with no block outstanding",
					$time, out_tdata);
				error_count++;
			end
			if (exp_q.size() != 0) begin
				expected = exp_q.pop_front();
				assert (out_tdata === expected) else begin
					$display("Error at %0t: out_tdata %h, expected %h",
						$time, out_tdata, expected);
					error_count++;
				end
			end
			if (check_latency && beat_q.size() != 0) begin
				latency = cycle - beat_q.pop_front();
				assert (latency == BLOCK_CYCLES) else begin
					$display("Error at %0t: block took %0d cycles, expected %0d",
						$time, latency, BLOCK_CYCLES);
					error_count++;
				end
			end
		end
	end

	task automatic read_stimulus();
		int fd;
		int n;
		int total;
		int c_in;
		int st_in;
		byte kind;
		string line;
		logic [aes_pkg::BLK_W-1:0] a;
		logic [aes_pkg::BLK_W-1:0] b;
		total = 0;
		fd = $fopen("verif/aes_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verif/aes_stimulus.txt");
			$display("Done: errors found");
			$finish;
		end else begin
			while ($fgets(line, fd) != 0) begin
				kind = line.getc(0);
				if (kind == "S") begin
					n = $sscanf(line, "S %d %d %h %h", c_in, st_in, a, b);
					assert (n == 4) else begin
						$display("malformed session line in stimulus file");
						error_count++;
					end
					sess_cbc.push_back(c_in[0]);
					sess_stall.push_back(st_in[0]);
					sess_key.push_back(a);
					sess_iv.push_back(b);
					sess_nblk.push_back(0);
				end else if (kind == "B" && sess_nblk.size() != 0) begin
					n = $sscanf(line, "B %h %h", a, b);
					assert (n == 2) else begin
						$display("malformed block line in stimulus file");
						error_count++;
					end
					blk_pt.push_back(a);
					blk_ct.push_back(b);
					sess_nblk[sess_nblk.size() - 1] += 1;
					total++;
				end
			end
			$fclose(fd);
			limit = total * (BLOCK_CYCLES + MAX_STALL) + 200;
		end
	endtask

	// called and returns on a falling edge
	task automatic send_beat(input logic [aes_pkg::BLK_W-1:0] data);
		in_tdata = data;
		in_tvalid = 1'b1;
		@(posedge clk);
		while (!in_tready)
			@(posedge clk);
		last_beat_cycle = cycle;
		@(negedge clk);
		in_tvalid = 1'b0;
	endtask

	task automatic run_session(input int s, input int first_blk);
		int errors_before;
		int pulses_before;
		int b;
		errors_before = error_count;
		pulses_before = done_pulses;
		cbc = sess_cbc[s];
		stall_en <= sess_stall[s];
		check_latency <= !sess_stall[s];
		beat_q.delete();
		send_beat(sess_key[s]);
		cbc = 1'b0; // mode is latched with the key
		if (sess_cbc[s])
			send_beat(sess_iv[s]);
		for (b = first_blk; b < first_blk + sess_nblk[s]; b++) begin
			exp_q.push_back(blk_ct[b]);
			send_beat(blk_pt[b]);
			if (!sess_stall[s])
				beat_q.push_back(last_beat_cycle);
		end
		source_done = 1'b1;
		while (done_pulses == pulses_before)
			@(negedge clk);
		source_done = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		assert (done_pulses == pulses_before + 1) else begin
			$display("Error at %0t: session %0d gave %0d processing_done pulses instead of one",
				$time, s, done_pulses - pulses_before);
			error_count++;
		end
		stall_en <= 1'b0;
		tests_run++;
		if (error_count != errors_before)
			tests_failed++;
		$display("test %0d: %s session, %0d blocks, %s: %s", tests_run,
			sess_cbc[s] ? "cbc" : "ecb", sess_nblk[s],
			sess_stall[s] ? "random stalls" : "no stalls",
			error_count == errors_before ? "pass" : "FAIL");
	endtask

	initial begin
		int s;
		int blk;
		int total_errors;
		in_tdata = '0;
		in_tvalid = 1'b0;
		cbc = 1'b0;
		source_done = 1'b0;
		out_tready = 1'b0;
		stall_en = 1'b0;
		check_latency = 1'b0;
		read_stimulus();

		repeat (2) @(posedge clk); // first reset edge has passed
		assert (!in_tready && !out_tvalid && !processing_done) else begin
			$display("Error at %0t: outputs not idle during reset", $time);
			error_count++;
		end
		while (reset)
			@(posedge clk);
		repeat (3) @(posedge clk);
		assert (in_tready === 1'b1) else begin
			$display("Error at %0t: in_tready low after reset, engine not waiting for a key",
				$time);
			error_count++;
		end
		tests_run++;
		if (error_count != 0)
			tests_failed++;
		$display("test %0d: reset state: %s", tests_run, error_count == 0 ? "pass" : "FAIL");

		@(negedge clk);
		blk = 0;
		for (s = 0; s < sess_cbc.size(); s++) begin
			run_session(s, blk);
			blk += sess_nblk[s];
		end

		total_errors = error_count + u_aes_stream_top.u_sva.assert_fails;
		$display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, u_aes_stream_top.u_sva.assert_fails);
		if (total_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
